//--- project.f
uart_cmd_pkg.sv
uart_tx.sv
uart_rx.sv
uart_cmd_master.sv
uart_cmd_top.sv
tb_uart_device.sv
tb_uart_cmd_top.sv

//--- tb_uart_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_top;

  localparam int CLK_FREQ   = 25_000_000;
  localparam int BAUD_RATE  = 3_125_000;
  localparam int B          = CLK_FREQ / BAUD_RATE;
  localparam int WRITE_CLKS = 22 * B + 3;
  // over 30 commands at about 400 cycles each, with wide margin
  localparam int MAX_CYCLES = 40000;

  logic clk;
  logic rst_n;
  logic cmd_vld;
  logic cmd_rdy;
  logic read_rdy;
  logic ser_tx;
  logic ser_rx;
  logic bad_parity;
  logic silent;
  logic [7:0] dev_hi;
  logic [7:0] dev_lo;
  int dev_err_cnt;
  int errors;
  int cycles;
  logic [15:0] lfsr;
  logic [7:0] shadow [128];
  uart_cmd_pkg::cmd_t cmd;
  uart_cmd_pkg::read_resp_t read_resp;

  uart_cmd_top #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) dut (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_vld(cmd_vld), .cmd_rdy(cmd_rdy),
    .rx(ser_rx), .tx(ser_tx), .read_rdy(read_rdy), .read_resp(read_resp)
  );

  tb_uart_device #(.CLKS_PER_BIT(B)) u_dev (
    .clk(clk), .dev_tx(ser_tx), .bad_parity(bad_parity), .silent(silent),
    .dev_rx(ser_rx), .last_hi(dev_hi), .last_lo(dev_lo), .frame_err_cnt(dev_err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin : watchdog
    wait (cycles >= MAX_CYCLES);
    $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input logic [7:0] exp_data, input logic exp_err,
                            input uart_cmd_pkg::read_resp_t resp);
    check_value({name, " data"}, 16'(exp_data), 16'(resp.data));
    check_value({name, " err"}, 16'(exp_err), 16'(resp.err));
  endtask

  // returns on the edge where the command is taken
  task automatic issue_cmd(input logic rd, input logic [6:0] addr, input logic [7:0] data);
    @(posedge clk);
    cmd.rd   <= rd;
    cmd.addr <= addr;
    cmd.data <= data;
    cmd_vld  <= 1'b1;
    @(posedge clk);
    while (!cmd_rdy) @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic write_reg(input string name, input logic [6:0] addr, input logic [7:0] data,
                           output int lat);
    int pulses;
    pulses = 0;
    lat = 0;
    issue_cmd(1'b0, addr, data);
    @(posedge clk);
    while (!cmd_rdy) begin
      if (read_rdy) pulses++;
      lat++;
      @(posedge clk);
    end
    if (read_rdy) pulses++;
    assert (pulses == 0) else begin
      $display("%s: read_rdy pulsed during a write command", name);
      errors++;
    end
    shadow[addr] = data;
  endtask

  task automatic read_reg(input string name, input logic [6:0] addr,
                          output uart_cmd_pkg::read_resp_t resp);
    issue_cmd(1'b1, addr, 8'h00);
    @(posedge clk);
    while (!read_rdy) @(posedge clk);
    resp = read_resp;
    assert (cmd_rdy === 1'b1) else begin
      $display("%s: cmd_rdy did not rise together with read_rdy", name);
      errors++;
    end
  endtask

  task automatic test_reset_state;
    repeat (2) @(posedge clk);
    check_value("reset_state in reset", 16'h0006, 16'({ser_tx, cmd_rdy, read_rdy}));
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    check_value("reset_state after reset", 16'h0006, 16'({ser_tx, cmd_rdy, read_rdy}));
  endtask

  task automatic test_write_frames;
    int lat;
    int err0;
    err0 = dev_err_cnt;
    write_reg("write_frames", 7'h15, 8'hA3, lat);
    check_value("write_frames high byte", 16'h0015, 16'(dev_hi));
    check_value("write_frames low byte", 16'h00A3, 16'(dev_lo));
    check_value("write_frames frame errors", 16'h0000, 16'(dev_err_cnt - err0));
    check_value("write_frames latency", 16'(WRITE_CLKS), 16'(lat));
  endtask

  task automatic test_read_back;
    uart_cmd_pkg::read_resp_t resp;
    read_reg("read_back", 7'h15, resp);
    check_resp("read_back written", 8'hA3, 1'b0, resp);
    read_reg("read_back", 7'h6A, resp);
    check_resp("read_back unwritten", 8'h00, 1'b0, resp);
  endtask

  task automatic test_random_access;
    logic [6:0] addrs [12];
    logic [7:0] v;
    logic [7:0] d;
    int lat;
    uart_cmd_pkg::read_resp_t resp;
    for (int i = 0; i < 12; i++) begin
      draw_bits(7, v);
      addrs[i] = v[6:0];
      draw_bits(8, d);
      write_reg("random_access", addrs[i], d, lat);
    end
    for (int i = 0; i < 12; i++) begin
      read_reg("random_access", addrs[i], resp);
      check_resp("random_access", shadow[addrs[i]], 1'b0, resp);
    end
  endtask

  task automatic test_parity_fault;
    uart_cmd_pkg::read_resp_t resp;
    @(posedge clk);
    bad_parity <= 1'b1;
    read_reg("parity_fault", 7'h15, resp);
    check_resp("parity_fault", 8'h00, 1'b1, resp);
    bad_parity <= 1'b0;
  endtask

  task automatic test_no_response;
    uart_cmd_pkg::read_resp_t resp;
    // good read first, its response must not survive the timeout
    read_reg("no_response prior", 7'h15, resp);
    check_resp("no_response prior", shadow[7'h15], 1'b0, resp);
    @(posedge clk);
    silent <= 1'b1;
    read_reg("no_response", 7'h15, resp);
    check_resp("no_response", 8'h00, 1'b1, resp);
    silent <= 1'b0;
    read_reg("no_response recovery", 7'h15, resp);
    check_resp("no_response recovery", shadow[7'h15], 1'b0, resp);
  endtask

  initial begin : main
    rst_n      = 1'b0;
    cmd        = '0;
    cmd_vld    = 1'b0;
    bad_parity = 1'b0;
    silent     = 1'b0;
    errors     = 0;
    cycles     = 0;
    lfsr       = 16'd41976;
    for (int i = 0; i < 128; i++) begin
      shadow[i] = '0;
    end
    test_reset_state();
    test_write_frames();
    test_read_back();
    test_random_access();
    test_parity_fault();
    test_no_response();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_uart_device.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_device #(
  parameter int CLKS_PER_BIT = 8
) (
  input  wire        clk,
  input  wire        dev_tx,
  input  wire        bad_parity,
  input  wire        silent,
  output logic       dev_rx,
  output logic [7:0] last_hi,
  output logic [7:0] last_lo,
  output int         frame_err_cnt
);

  logic [7:0] regs [128];

  // mid-bit sampling from the falling start edge
  task automatic recv_frame(output logic [7:0] b);
    logic st;
    logic par;
    logic stp;
    @(negedge dev_tx);
    repeat (CLKS_PER_BIT / 2) @(posedge clk);
    st = dev_tx;
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      b[i] = dev_tx;
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    par = dev_tx;
    repeat (CLKS_PER_BIT) @(posedge clk);
    stp = dev_tx;
    if (st !== 1'b0 || par !== ~^b || stp !== 1'b1) begin
      frame_err_cnt = frame_err_cnt + 1;
    end
  endtask

  task automatic send_frame(input logic [7:0] b, input logic flip);
    logic [10:0] bits;
    bits = {1'b1, flip ? ^b : ~^b, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      dev_rx <= bits[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  initial begin : serve
    logic [7:0] hi;
    logic [7:0] lo;
    dev_rx        = 1'b1;
    last_hi       = '0;
    last_lo       = '0;
    frame_err_cnt = 0;
    for (int i = 0; i < 128; i++) begin
      regs[i] = '0;
    end
    forever begin
      recv_frame(hi);
      last_hi = hi;
      recv_frame(lo);
      last_lo = lo;
      if (hi[7]) begin
        // turnaround before the response
        repeat (2 * CLKS_PER_BIT) @(posedge clk);
        if (!silent) begin
          send_frame(regs[hi[6:0]], bad_parity);
        end
      end else begin
        regs[hi[6:0]] = lo;
      end
    end
  end

endmodule

`default_nettype wire

//--- uart_cmd_master.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_master #(
  parameter int CLKS_PER_BIT = 8
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire uart_cmd_pkg::cmd_t      cmd,
  input  wire                          cmd_vld,
  output logic                         cmd_rdy,
  output logic [7:0]                   tx_byte,
  output logic                         tx_start,
  input  wire                          tx_busy,
  input  wire                          rx_vld,
  input  wire uart_cmd_pkg::rx_byte_t  rx_byte,
  output logic                         read_rdy,
  output uart_cmd_pkg::read_resp_t     read_resp
);

  localparam int TIMEOUT_CLKS = uart_cmd_pkg::RESP_TIMEOUT_BITS * CLKS_PER_BIT;
  localparam int TW           = $clog2(TIMEOUT_CLKS);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HI,
    S_LO,
    S_WAIT,
    S_RESP
  } state_t;

  state_t             state;
  uart_cmd_pkg::cmd_t cmd_q;
  logic               lo_sent;
  logic [TW-1:0]      to_cnt;
  logic               accept;
  logic               timeout;
  logic               rx_ok;

  assign accept  = cmd_vld & cmd_rdy;
  assign timeout = (to_cnt == TW'(TIMEOUT_CLKS - 1));
  assign rx_ok   = ~rx_byte.parity_err & ~rx_byte.frame_err;

  // next frame goes out as soon as the transmitter is free
  assign tx_start = !tx_busy && (state == S_HI || (state == S_LO && !lo_sent));
  assign tx_byte  = (state == S_HI) ? {cmd_q.rd, cmd_q.addr} : cmd_q.data;

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      cmd_rdy  <= 1'b1;
      lo_sent  <= 1'b0;
      to_cnt   <= '0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            state   <= S_HI;
            cmd_rdy <= 1'b0;
          end
        end
        S_HI: begin
          lo_sent <= 1'b0;
          if (tx_start) begin
            state <= S_LO;
          end
        end
        S_LO: begin
          if (tx_start) begin
            lo_sent <= 1'b1;
          end else if (!tx_busy) begin
            // second frame fully on the line
            if (cmd_q.rd) begin
              state  <= S_WAIT;
              to_cnt <= '0;
            end else begin
              state   <= S_IDLE;
              cmd_rdy <= 1'b1;
            end
          end
        end
        S_WAIT: begin
          if (rx_vld) begin
            state  <= S_RESP;
            to_cnt <= '0;
          end else if (timeout) begin
            state <= S_RESP;
          end else begin
            to_cnt <= to_cnt + TW'(1);
          end
        end
        S_RESP: begin
          state    <= S_IDLE;
          cmd_rdy  <= 1'b1;
          read_rdy <= 1'b1;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // bad frame or no frame both read as zero with err
  always_ff @(posedge clk) begin
    if (state == S_WAIT && (rx_vld || timeout)) begin
      if (rx_vld && rx_ok) begin
        read_resp.data <= rx_byte.data;
        read_resp.err  <= 1'b0;
      end else begin
        read_resp.data <= '0;
        read_resp.err  <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) (state != S_IDLE) |-> !cmd_rdy)
    else $error("uart_cmd_master: cmd_rdy high while busy");

  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> cmd_q.rd)
    else $error("uart_cmd_master: read response for a write command");

endmodule

`default_nettype wire

//--- uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  // bits per frame: start, 8 data, parity, stop
  localparam int FRAME_BITS = 11;

  // bit times allowed between our last stop bit and a response
  localparam int RESP_TIMEOUT_BITS = 40;

  // command word, first byte on the line is {rd, addr}
  typedef struct packed {
    logic       rd;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  // one frame as seen by the receiver
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
  } rx_byte_t;

  // returned to the host with read_rdy
  typedef struct packed {
    logic [7:0] data;
    logic       err;
  } read_resp_t;

endpackage

`default_nettype wire

//--- uart_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top #(
  parameter int CLK_FREQ  = 25_000_000,
  parameter int BAUD_RATE = 3_125_000
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire uart_cmd_pkg::cmd_t   cmd,
  input  wire                       cmd_vld,
  output logic                      cmd_rdy,
  input  wire                       rx,
  output logic                      tx,
  output logic                      read_rdy,
  output uart_cmd_pkg::read_resp_t  read_resp
);

  // integer division only, needs at least 4 clocks per bit
  localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;

  logic [7:0]             tx_byte;
  logic                   tx_start;
  logic                   tx_busy;
  logic                   rx_vld;
  uart_cmd_pkg::rx_byte_t rx_byte;

  uart_cmd_master #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_byte   (tx_byte),
    .tx_start  (tx_start),
    .tx_busy   (tx_busy),
    .rx_vld    (rx_vld),
    .rx_byte   (rx_byte),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_vld  (rx_vld),
    .rx_byte (rx_byte)
  );

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    rx,
  output logic                   rx_vld,
  output uart_cmd_pkg::rx_byte_t rx_byte
);

  localparam int CW       = $clog2(CLKS_PER_BIT);
  localparam int HALF     = CLKS_PER_BIT / 2;
  localparam int PAR_IDX  = uart_cmd_pkg::FRAME_BITS - 2;
  localparam int STOP_IDX = uart_cmd_pkg::FRAME_BITS - 1;

  logic          rx_s1;
  logic          rx_s2;
  logic          rx_q;
  logic          start_edge;
  logic          active;
  logic [CW-1:0] clk_cnt;
  logic [CW-1:0] cnt_target;
  logic [3:0]    bit_idx;
  logic          sample;
  logic [7:0]    data_sr;
  logic          par_bit;

  // two-stage synchronizer plus a delayed copy for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_q  <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_q  <= rx_s2;
    end
  end

  assign start_edge = rx_q & ~rx_s2;

  // half a bit to the middle of start, then full bits
  assign cnt_target = (bit_idx == 4'd0) ? CW'(HALF - 1) : CW'(CLKS_PER_BIT - 1);
  assign sample     = active && (clk_cnt == cnt_target);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active  <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      rx_vld  <= 1'b0;
    end else begin
      rx_vld <= 1'b0;
      if (!active) begin
        clk_cnt <= '0;
        bit_idx <= '0;
        if (start_edge) begin
          active <= 1'b1;
        end
      end else if (sample) begin
        clk_cnt <= '0;
        if (bit_idx == 4'd0 && rx_s2) begin
          // glitch, not a real start bit
          active <= 1'b0;
        end else if (bit_idx == 4'(STOP_IDX)) begin
          active <= 1'b0;
          rx_vld <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 4'd1;
        end
      end else begin
        clk_cnt <= clk_cnt + CW'(1);
      end
    end
  end

  // data lsb first, then parity, then stop
  always_ff @(posedge clk) begin
    if (sample) begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
        data_sr <= {rx_s2, data_sr[7:1]};
      end
      if (bit_idx == 4'(PAR_IDX)) begin
        par_bit <= rx_s2;
      end
      if (bit_idx == 4'(STOP_IDX)) begin
        rx_byte.data       <= data_sr;
        rx_byte.parity_err <= (par_bit != ~^data_sr);
        rx_byte.frame_err  <= ~rx_s2;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) active |-> (bit_idx <= 4'(STOP_IDX)))
    else $error("uart_rx: bit index past the stop bit");

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire  [7:0] tx_byte,
  input  wire        tx_start,
  output logic       tx,
  output logic       tx_busy
);

  localparam int CW       = $clog2(CLKS_PER_BIT);
  localparam int FB       = uart_cmd_pkg::FRAME_BITS;
  localparam int LAST_BIT = FB - 1;

  logic [FB-1:0] shreg;
  logic [CW-1:0] clk_cnt;
  logic [3:0]    bit_cnt;
  logic          bit_done;

  assign bit_done = (clk_cnt == CW'(CLKS_PER_BIT - 1));

  // line follows bit 0 of the shift register, all ones when idle
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg   <= '1;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx_busy <= 1'b0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        // stop, odd parity, data, start
        shreg   <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
        clk_cnt <= '0;
        bit_cnt <= '0;
        tx_busy <= 1'b1;
      end
    end else if (bit_done) begin
      clk_cnt <= '0;
      shreg   <= {1'b1, shreg[FB-1:1]};
      if (bit_cnt == 4'(LAST_BIT)) begin
        tx_busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + CW'(1);
    end
  end

  // the master must wait for the previous frame to finish
  assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
    else $error("uart_tx: tx_start while a frame is in progress");

endmodule

`default_nettype wire
